// ==== common/matrix_power_pkg.sv ====
package matrix_power_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Row and column counts, fixed by the host register map
  localparam int INDEX_W = 16;

  // Integer exponent applied to every element
  localparam int EXP_W = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Matrix shape as sampled on START
  // size_i counts rows, size_j counts columns
  typedef struct packed {
    logic [INDEX_W-1:0] size_i;
    logic [INDEX_W-1:0] size_j;
  } matrix_shape_t;

  // Controller FSM states
  typedef enum logic [1:0] {
    // Idle, waiting for START
    STARTER = 2'd0,
    // Waiting for the first element of a row
    INPUT_I = 2'd1,
    // Waiting for a later element of the row
    INPUT_J = 2'd2,
    // Element in the power unit, waiting for its result
    ENDER   = 2'd3
  } power_ctrl_state_e;

endpackage

// ==== src/vector_power_unit.sv ====
`timescale 1ns/1ps

module vector_power_unit #(
  parameter int DATA_SIZE = 64
) (
  input  logic                               CLK,
  input  logic                               RST,

  // Request from the controller
  input  logic                               power_start,
  input  logic [DATA_SIZE-1:0]               power_base,
  input  logic [matrix_power_pkg::EXP_W-1:0] power_exponent,

  // Result, valid while power_ready is high
  output logic                               power_ready,
  output logic [DATA_SIZE-1:0]               power_result
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Busy from the load cycle until the result cycle
  logic                               busy_q;

  // Multiplications still to do
  logic [matrix_power_pkg::EXP_W-1:0] count_q;

  // Operand and running product
  logic [DATA_SIZE-1:0]               base_q;
  logic [DATA_SIZE-1:0]               acc_q;

  // One multiply this cycle
  logic                               step;
  // Counter exhausted, product is final
  logic                               done;

  assign step = busy_q && (count_q != '0);
  assign done = busy_q && (count_q == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q      <= 1'b0;
      count_q     <= '0;
      power_ready <= 1'b0;
    end else begin
      // Ready is a single-cycle strobe
      power_ready <= 1'b0;

      if (power_start) begin
        // Load cycle
        busy_q  <= 1'b1;
        count_q <= power_exponent;
      end else if (step) begin
        count_q <= count_q - 1'b1;
      end else if (done) begin
        // Result cycle, back to idle
        busy_q      <= 1'b0;
        power_ready <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (power_start) begin
      base_q <= power_base;
      // x^0 = 1
      acc_q  <= DATA_SIZE'(1);
    end else if (step) begin
      // Keep the low DATA_SIZE bits, i.e. modulo 2^DATA_SIZE
      acc_q <= acc_q * base_q;
    end

    if (done) begin
      power_result <= acc_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Controller must hold off while an element is in flight
  assert property (@(posedge CLK) disable iff (RST) busy_q |-> !power_start)
    else $error("power_start raised while the power unit is busy");

  // Result strobe never stretches
  assert property (@(posedge CLK) disable iff (RST) power_ready |=> !power_ready)
    else $error("power_ready held for more than one cycle");

endmodule

// ==== matrix_power/matrix_power_ctrl.sv ====
`timescale 1ns/1ps

module matrix_power_ctrl #(
  parameter int DATA_SIZE = 64
) (
  input  logic                                CLK,
  input  logic                                RST,

  // Host side
  input  logic                                START,
  input  matrix_power_pkg::matrix_shape_t     SHAPE_IN,
  input  logic [matrix_power_pkg::EXP_W-1:0]  EXPONENT_IN,
  input  logic                                DATA_IN_I_ENABLE,
  input  logic                                DATA_IN_J_ENABLE,
  input  logic [DATA_SIZE-1:0]                DATA_IN,
  output logic                                READY,
  output logic                                DATA_OUT_I_ENABLE,
  output logic                                DATA_OUT_J_ENABLE,
  output logic [DATA_SIZE-1:0]                DATA_OUT,

  // Power unit side
  input  logic                                power_ready,
  input  logic [DATA_SIZE-1:0]                power_result,
  output logic                                power_start,
  output logic [DATA_SIZE-1:0]                power_base,
  output logic [matrix_power_pkg::EXP_W-1:0]  power_exponent
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  matrix_power_pkg::power_ctrl_state_e       state_q;

  // Job parameters, held from START to READY
  matrix_power_pkg::matrix_shape_t           shape_q;
  logic [matrix_power_pkg::EXP_W-1:0]        exponent_q;

  // Position of the element in flight
  logic [matrix_power_pkg::INDEX_W-1:0]      index_i;
  logic [matrix_power_pkg::INDEX_W-1:0]      index_j;

  // Decodes
  logic                                      job_start;
  logic                                      accept_i;
  logic                                      accept_j;
  logic                                      last_col;
  logic                                      last_row;

  assign job_start = (state_q == matrix_power_pkg::STARTER) && START;
  assign accept_i  = (state_q == matrix_power_pkg::INPUT_I) && DATA_IN_I_ENABLE;
  assign accept_j  = (state_q == matrix_power_pkg::INPUT_J) && DATA_IN_J_ENABLE;

  assign last_col = (index_j == shape_q.size_j - 1'b1);
  assign last_row = (index_i == shape_q.size_i - 1'b1);

  // Exponent is constant for the whole job
  assign power_exponent = exponent_q;

  ////////////////////////////////////////////////////////////////////////////
  // Row and column FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q           <= matrix_power_pkg::STARTER;
      index_i           <= '0;
      index_j           <= '0;
      power_start       <= 1'b0;
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      DATA_OUT          <= '0;
    end else begin
      // All strobes default low
      power_start       <= 1'b0;
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;

      case (state_q)
        matrix_power_pkg::STARTER: begin
          if (START) begin
            index_i <= '0;
            index_j <= '0;
            state_q <= matrix_power_pkg::INPUT_I;
          end
        end
        matrix_power_pkg::INPUT_I: begin
          // First element of a row
          if (accept_i) begin
            power_start <= 1'b1;
            state_q     <= matrix_power_pkg::ENDER;
          end
        end
        matrix_power_pkg::INPUT_J: begin
          if (accept_j) begin
            power_start <= 1'b1;
            state_q     <= matrix_power_pkg::ENDER;
          end
        end
        matrix_power_pkg::ENDER: begin
          if (power_ready) begin
            DATA_OUT          <= power_result;
            DATA_OUT_J_ENABLE <= 1'b1;

            if (last_col && last_row) begin
              // Whole matrix done
              DATA_OUT_I_ENABLE <= 1'b1;
              READY             <= 1'b1;
              state_q           <= matrix_power_pkg::STARTER;
            end else if (last_col) begin
              // End of row, next one
              DATA_OUT_I_ENABLE <= 1'b1;
              index_i           <= index_i + 1'b1;
              index_j           <= '0;
              state_q           <= matrix_power_pkg::INPUT_I;
            end else begin
              index_j <= index_j + 1'b1;
              state_q <= matrix_power_pkg::INPUT_J;
            end
          end
        end
        default: begin
          state_q <= matrix_power_pkg::STARTER;
        end
      endcase
    end
  end

  // Job parameters and the element handed to the power unit
  always_ff @(posedge CLK) begin
    if (job_start) begin
      shape_q    <= SHAPE_IN;
      exponent_q <= EXPONENT_IN;
    end
    if (accept_i || accept_j) begin
      power_base <= DATA_IN;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Empty matrices are not supported
  assert property (@(posedge CLK) disable iff (RST)
    job_start |-> (SHAPE_IN.size_i != '0) && (SHAPE_IN.size_j != '0))
    else $error("START with a zero matrix size");

  // Host sends an element only when the FSM waits for that kind
  assert property (@(posedge CLK) disable iff (RST)
    DATA_IN_I_ENABLE |-> (state_q == matrix_power_pkg::INPUT_I))
    else $error("DATA_IN_I_ENABLE while not expecting a row start");

  assert property (@(posedge CLK) disable iff (RST)
    DATA_IN_J_ENABLE |-> (state_q == matrix_power_pkg::INPUT_J))
    else $error("DATA_IN_J_ENABLE while not expecting a row element");

  // Strobe nesting seen by the host
  assert property (@(posedge CLK) disable iff (RST)
    (READY |-> DATA_OUT_I_ENABLE) and (DATA_OUT_I_ENABLE |-> DATA_OUT_J_ENABLE))
    else $error("output strobes out of order");

endmodule

// ==== matrix_power/matrix_power_top.sv ====
`timescale 1ns/1ps

module matrix_power_top #(
  parameter int DATA_SIZE = 64
) (
  input  logic                               CLK,
  input  logic                               RST,

  // Control
  input  logic                               START,
  output logic                               READY,
  input  logic                               DATA_IN_I_ENABLE,
  input  logic                               DATA_IN_J_ENABLE,
  output logic                               DATA_OUT_I_ENABLE,
  output logic                               DATA_OUT_J_ENABLE,

  // Data
  input  matrix_power_pkg::matrix_shape_t    SHAPE_IN,
  input  logic [matrix_power_pkg::EXP_W-1:0] EXPONENT_IN,
  input  logic [DATA_SIZE-1:0]               DATA_IN,
  output logic [DATA_SIZE-1:0]               DATA_OUT
);

  ////////////////////////////////////////////////////////////////////////////
  // Controller to power unit
  ////////////////////////////////////////////////////////////////////////////

  logic                               power_start;
  logic [DATA_SIZE-1:0]               power_base;
  logic [matrix_power_pkg::EXP_W-1:0] power_exponent;
  logic                               power_ready;
  logic [DATA_SIZE-1:0]               power_result;

  // Row and column sequencing
  matrix_power_ctrl #(
    .DATA_SIZE(DATA_SIZE)
  ) u_ctrl (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .SHAPE_IN         (SHAPE_IN),
    .EXPONENT_IN      (EXPONENT_IN),
    .DATA_IN_I_ENABLE (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE (DATA_IN_J_ENABLE),
    .DATA_IN          (DATA_IN),
    .READY            (READY),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE),
    .DATA_OUT         (DATA_OUT),
    .power_ready      (power_ready),
    .power_result     (power_result),
    .power_start      (power_start),
    .power_base       (power_base),
    .power_exponent   (power_exponent)
  );

  // One element at a time
  vector_power_unit #(
    .DATA_SIZE(DATA_SIZE)
  ) u_power (
    .CLK           (CLK),
    .RST           (RST),
    .power_start   (power_start),
    .power_base    (power_base),
    .power_exponent(power_exponent),
    .power_ready   (power_ready),
    .power_result  (power_result)
  );

endmodule

// ==== dv/matrix_power_tb.sv ====
`timescale 1ns/1ps

module matrix_power_tb;

  localparam int DATA_SIZE = 64;
  localparam int TIMEOUT_CYCLES = 300;
  // Right-shift Galois taps for x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic                                 CLK;
  logic                                 RST;
  logic                                 START;
  matrix_power_pkg::matrix_shape_t      SHAPE_IN;
  logic [matrix_power_pkg::EXP_W-1:0]   EXPONENT_IN;
  logic                                 DATA_IN_I_ENABLE;
  logic                                 DATA_IN_J_ENABLE;
  logic [DATA_SIZE-1:0]                 DATA_IN;
  logic                                 READY;
  logic                                 DATA_OUT_I_ENABLE;
  logic                                 DATA_OUT_J_ENABLE;
  logic [DATA_SIZE-1:0]                 DATA_OUT;

  // Reference results of the running job in input order
  logic [DATA_SIZE-1:0]                 expected [0:255];
  matrix_power_pkg::matrix_shape_t      job_shape;
  int                                   out_count;
  logic [matrix_power_pkg::INDEX_W-1:0] row_cnt;
  logic [matrix_power_pkg::INDEX_W-1:0] col_cnt;
  logic                                 last_col_exp;
  logic                                 last_elem_exp;
  logic [31:0]                          lfsr_q;
  logic                                 idle_check;
  logic                                 aborted;
  int                                   fails;
  int                                   tests_passed;
  int                                   tests_failed;

  matrix_power_top #(.DATA_SIZE(DATA_SIZE)) u_matrix_power_top (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Own row and column tracking of the output stream
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      job_shape <= '0;
      out_count <= 0;
      row_cnt   <= '0;
      col_cnt   <= '0;
    end else if (START) begin
      job_shape <= SHAPE_IN;
      out_count <= 0;
      row_cnt   <= '0;
      col_cnt   <= '0;
    end else if (DATA_OUT_J_ENABLE) begin
      out_count <= out_count + 1;
      col_cnt   <= last_col_exp ? '0 : col_cnt + 1'b1;
      row_cnt   <= last_col_exp ? row_cnt + 1'b1 : row_cnt;
    end
  end

  assign last_col_exp  = (col_cnt == job_shape.size_j - 1'b1);
  assign last_elem_exp = last_col_exp && (row_cnt == job_shape.size_i - 1'b1);

  // Every element against the reference
  assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_J_ENABLE |-> (DATA_OUT == expected[out_count]))
    else begin
      fails++;
      $display("CHECK FAILED DATA_OUT: got %h expected %h",
               $sampled(DATA_OUT), $sampled(expected[out_count]));
    end

  // Row end strobe only on the last column
  assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_I_ENABLE == (DATA_OUT_J_ENABLE && last_col_exp))
    else begin
      fails++;
      $display("CHECK FAILED DATA_OUT_I_ENABLE: got %h expected %h",
               $sampled(DATA_OUT_I_ENABLE), $sampled(DATA_OUT_J_ENABLE && last_col_exp));
    end

  // Job done strobe only with the last element
  assert property (@(posedge CLK) disable iff (RST)
    READY == (DATA_OUT_J_ENABLE && last_elem_exp))
    else begin
      fails++;
      $display("CHECK FAILED READY: got %h expected %h",
               $sampled(READY), $sampled(DATA_OUT_J_ENABLE && last_elem_exp));
    end

  // Quiet outputs and idle FSM before any START
  assert property (@(posedge CLK) disable iff (RST)
    idle_check |-> !READY && !DATA_OUT_I_ENABLE && !DATA_OUT_J_ENABLE && (DATA_OUT == '0) &&
                   (u_matrix_power_top.u_ctrl.state_q == matrix_power_pkg::STARTER))
    else begin
      fails++;
      $display("CHECK FAILED idle outputs: READY %h I %h J %h DATA_OUT %h state %h",
               $sampled(READY), $sampled(DATA_OUT_I_ENABLE), $sampled(DATA_OUT_J_ENABLE),
               $sampled(DATA_OUT), $sampled(u_matrix_power_top.u_ctrl.state_q));
    end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic lfsr_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lsb ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    return lsb;
  endfunction

  function automatic logic [DATA_SIZE-1:0] rand_word();
    logic [DATA_SIZE-1:0] w;
    for (int k = 0; k < DATA_SIZE; k++) begin
      w = {w[DATA_SIZE-2:0], lfsr_bit()};
    end
    return w;
  endfunction

  // Square and multiply modulo 2^DATA_SIZE
  function automatic logic [DATA_SIZE-1:0] pow_ref(input logic [DATA_SIZE-1:0] b,
                                                   input logic [matrix_power_pkg::EXP_W-1:0] e);
    logic [DATA_SIZE-1:0] r;
    r = DATA_SIZE'(1);
    for (int k = matrix_power_pkg::EXP_W - 1; k >= 0; k--) begin
      r = r * r;
      if (e[k]) r = r * b;
    end
    return r;
  endfunction

  // Called right after a falling edge
  task automatic run_job(input int rows, input int cols,
                         input logic [matrix_power_pkg::EXP_W-1:0] exponent);
    logic [DATA_SIZE-1:0] base;
    int                   wait_cnt;
    if (aborted) return;
    START       = 1'b1;
    SHAPE_IN    = '{size_i: rows[15:0], size_j: cols[15:0]};
    EXPONENT_IN = exponent;
    @(negedge CLK);
    START = 1'b0;
    for (int n = 0; n < rows * cols; n++) begin
      base        = rand_word();
      expected[n] = pow_ref(base, exponent);
      // First element of a row uses the I strobe
      DATA_IN          = base;
      DATA_IN_I_ENABLE = (n % cols == 0);
      DATA_IN_J_ENABLE = (n % cols != 0);
      @(negedge CLK);
      DATA_IN_I_ENABLE = 1'b0;
      DATA_IN_J_ENABLE = 1'b0;
      wait_cnt = 0;
      while (!DATA_OUT_J_ENABLE && wait_cnt < TIMEOUT_CYCLES) begin
        @(negedge CLK);
        wait_cnt++;
      end
      if (!DATA_OUT_J_ENABLE) begin
        $display("Timeout: no output strobe for element %0d after %0d cycles", n, wait_cnt);
        fails++;
        aborted = 1'b1;
        return;
      end
    end
    // Last output is sampled on the next rising edge
    @(negedge CLK);
  endtask

  task automatic end_test(input string name, input int fails_before);
    if (fails == fails_before) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int fails_before;
    RST              = 1'b1;
    START            = 1'b0;
    SHAPE_IN         = '0;
    EXPONENT_IN      = '0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    DATA_IN          = '0;
    lfsr_q           = 32'h0b5309fe;
    idle_check       = 1'b0;
    aborted          = 1'b0;
    fails            = 0;
    tests_passed     = 0;
    tests_failed     = 0;
    repeat (16) @(negedge CLK);
    RST = 1'b0;

    fails_before = fails;
    idle_check   = 1'b1;
    repeat (20) @(negedge CLK);
    idle_check = 1'b0;
    end_test("idle after reset", fails_before);

    fails_before = fails;
    run_job(3, 4, 3);
    end_test("3x4 cube and row strobes", fails_before);

    fails_before = fails;
    run_job(2, 2, 0);
    run_job(2, 2, 1);
    end_test("2x2 exponents 0 and 1", fails_before);

    fails_before = fails;
    run_job(1, 1, 7);
    end_test("1x1 exponent 7", fails_before);

    // Starts on the cycle after READY
    fails_before = fails;
    run_job(2, 3, 2);
    end_test("back-to-back 2x3 square", fails_before);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== matrix_power.f ====
common/matrix_power_pkg.sv
src/vector_power_unit.sv
matrix_power/matrix_power_ctrl.sv
matrix_power/matrix_power_top.sv
dv/matrix_power_tb.sv

// ==== Bender.yml ====
package:
  name: matrix_power

sources:
  - files:
      - common/matrix_power_pkg.sv
      - src/vector_power_unit.sv
      - matrix_power/matrix_power_ctrl.sv
      - matrix_power/matrix_power_top.sv
  - target: test
    files:
      - dv/matrix_power_tb.sv
